// File: include/pcg_params.svh
`ifndef PCG_PARAMS_SVH
`define PCG_PARAMS_SVH

// --------------------------------------------------
// datapath sizes
// --------------------------------------------------
`define PCG_OP_W   32
`define PCG_R      2

// interleaved levels at the butterfly input
`define PCG_LVL_NB 3

// words held per level before distribution
`define PCG_DEPTH  2

// --------------------------------------------------
// bit positions inside a flag vector
// --------------------------------------------------
`define PCG_FLAG_SOL 0
`define PCG_FLAG_EOL 1
`define PCG_FLAG_SOB 2
`define PCG_FLAG_EOB 3

`endif

// File: hw/pcg_pkg.sv
`default_nettype none

`include "pcg_params.svh"

package pcg_pkg;

  localparam int LVL_W = ($clog2(`PCG_LVL_NB) > 0) ? $clog2(`PCG_LVL_NB) : 1;
  localparam int PTR_W = $clog2(`PCG_DEPTH) + 1;

  // --------------------------------------------------
  // data
  // --------------------------------------------------
  typedef logic [`PCG_OP_W-1:0]        coef_t;
  // coefficient 0 sits in the low bits
  typedef logic [`PCG_R*`PCG_OP_W-1:0] word_t;
  typedef logic [3:0]                  flags_t;

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  typedef logic [LVL_W-1:0]      lvl_t;
  typedef logic [`PCG_LVL_NB-1:0] lvl_mask_t;
  // all ones means the register is empty
  typedef logic [PTR_W-1:0]      sreg_ptr_t;

endpackage

`default_nettype wire

// File: hw/pcg_level_rotor.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcg_params.svh"

module pcg_level_rotor
  import pcg_pkg::*;
(
  input  logic      clk,
  input  logic      s_rst_n,
  input  logic      step,
  input  logic      eol,
  output lvl_t      lvl,
  output lvl_mask_t lvl_mask
);

  lvl_t      lvl_next;
  lvl_mask_t mask_next;

  // index and one-hot move together
  always_comb begin
    lvl_next  = lvl;
    mask_next = lvl_mask;
    if (step) begin
      if (eol || (lvl == lvl_t'(`PCG_LVL_NB - 1))) begin
        lvl_next  = '0;
        mask_next = lvl_mask_t'(1);
      end else begin
        lvl_next  = lvl + 1'b1;
        mask_next = {lvl_mask[`PCG_LVL_NB-2:0], lvl_mask[`PCG_LVL_NB-1]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      lvl      <= '0;
      lvl_mask <= lvl_mask_t'(1);
    end else begin
      lvl      <= lvl_next;
      lvl_mask <= mask_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/pcg_acc_sreg.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcg_params.svh"

module pcg_acc_sreg
  import pcg_pkg::*;
(
  input  logic   clk,
  input  logic   s_rst_n,
  input  logic   wr,
  input  word_t  wr_data,
  input  flags_t wr_flags,
  input  logic   xfer,
  output logic   has_word,
  output word_t  head_data,
  output flags_t head_flags
);

  sreg_ptr_t rp;
  word_t     data_q  [`PCG_DEPTH];
  flags_t    flags_q [`PCG_DEPTH];
  logic      full;
  logic      wr_ok;

  // --------------------------------------------------
  // pointer
  // --------------------------------------------------
  assign full     = (rp == sreg_ptr_t'(`PCG_DEPTH - 1));
  assign has_word = (rp != '1);

  // a write into a full register is dropped unless the head leaves
  assign wr_ok = wr & (~full | xfer);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rp <= '1;
    end else if (wr_ok && !xfer) begin
      rp <= rp + 1'b1;
    end else if (!wr_ok && xfer) begin
      rp <= rp - 1'b1;
    end
  end

  // --------------------------------------------------
  // storage, newest at index 0
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      data_q[0]  <= wr_data;
      flags_q[0] <= wr_flags;
      for (int i = 1; i < `PCG_DEPTH; i++) begin
        data_q[i]  <= data_q[i-1];
        flags_q[i] <= flags_q[i-1];
      end
    end
  end

  // oldest word sits at the pointer
  always_comb begin
    head_data  = '0;
    head_flags = '0;
    for (int i = 0; i < `PCG_DEPTH; i++) begin
      if (rp == sreg_ptr_t'(i)) begin
        head_data  = data_q[i];
        head_flags = flags_q[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/pcg_dist_sreg.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcg_params.svh"

module pcg_dist_sreg
  import pcg_pkg::*;
(
  input  logic   clk,
  input  logic   s_rst_n,
  input  logic   load,
  input  word_t  load_data,
  input  flags_t load_flags,
  input  logic   rd,
  output logic   empty,
  output logic   head_avail,
  output coef_t  head_coef,
  output flags_t head_flags
);

  word_t              data_q;
  flags_t             flags_q;
  logic [`PCG_R-1:0]  vld_q;
  logic               first;
  logic               last;

  // --------------------------------------------------
  // valid vector
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      vld_q <= '0;
    end else if (load) begin
      vld_q <= '1;
    end else if (rd) begin
      vld_q <= {1'b0, vld_q[`PCG_R-1:1]};
    end
  end

  // --------------------------------------------------
  // payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      data_q  <= load_data;
      flags_q <= load_flags;
    end else if (rd) begin
      // next coefficient moves into slot 0
      data_q <= {{`PCG_OP_W{1'b0}}, data_q[`PCG_R*`PCG_OP_W-1:`PCG_OP_W]};
    end
  end

  assign empty      = ~vld_q[0];
  assign head_avail = vld_q[0];
  assign head_coef  = data_q[`PCG_OP_W-1:0];

  // position of the head coefficient inside its word
  assign first = &vld_q;
  assign last  = ~vld_q[1];

  // level flags on every coefficient, word flags on the ends only
  always_comb begin
    head_flags               = '0;
    head_flags[`PCG_FLAG_SOL] = flags_q[`PCG_FLAG_SOL];
    head_flags[`PCG_FLAG_EOL] = flags_q[`PCG_FLAG_EOL];
    head_flags[`PCG_FLAG_SOB] = flags_q[`PCG_FLAG_SOB] & first;
    head_flags[`PCG_FLAG_EOB] = flags_q[`PCG_FLAG_EOB] & last;
  end

endmodule

`default_nettype wire

// File: hw/pcg_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcg_params.svh"

module pcg_pipe_top
  import pcg_pkg::*;
(
  input  logic   clk,
  input  logic   s_rst_n,
  input  word_t  in_data,
  input  flags_t in_flags,
  input  logic   in_avail,
  input  logic   in_inc,
  output coef_t  out_data,
  output flags_t out_flags,
  output logic   out_avail
);

  lvl_mask_t               wr_mask;
  lvl_t                    rd_lvl;
  lvl_mask_t               rd_mask;

  coef_t                   lane_coef  [`PCG_LVL_NB];
  flags_t                  lane_flags [`PCG_LVL_NB];
  logic [`PCG_LVL_NB-1:0]  lane_avail;

  coef_t                   sel_coef;
  flags_t                  sel_flags;
  logic                    sel_avail;

  // --------------------------------------------------
  // write side level
  // --------------------------------------------------
  pcg_level_rotor wr_rotor_inst (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .step     (in_avail),
    .eol      (in_flags[`PCG_FLAG_EOL]),
    .lvl      (),
    .lvl_mask (wr_mask)
  );

  // --------------------------------------------------
  // per-level lanes
  // --------------------------------------------------
  for (genvar l = 0; l < `PCG_LVL_NB; l++) begin : gen_lane
    logic   acc_wr;
    logic   acc_has_word;
    word_t  acc_data;
    flags_t acc_flags;
    logic   dist_empty;
    logic   dist_rd;
    logic   xfer;

    assign acc_wr  = in_avail & wr_mask[l];
    assign dist_rd = in_inc & rd_mask[l];
    // oldest word moves across once the distribution side drains
    assign xfer    = dist_empty & acc_has_word;

    pcg_acc_sreg acc_inst (
      .clk        (clk),
      .s_rst_n    (s_rst_n),
      .wr         (acc_wr),
      .wr_data    (in_data),
      .wr_flags   (in_flags),
      .xfer       (xfer),
      .has_word   (acc_has_word),
      .head_data  (acc_data),
      .head_flags (acc_flags)
    );

    pcg_dist_sreg dist_inst (
      .clk        (clk),
      .s_rst_n    (s_rst_n),
      .load       (xfer),
      .load_data  (acc_data),
      .load_flags (acc_flags),
      .rd         (dist_rd),
      .empty      (dist_empty),
      .head_avail (lane_avail[l]),
      .head_coef  (lane_coef[l]),
      .head_flags (lane_flags[l])
    );
  end

  // --------------------------------------------------
  // read side level and mux
  // --------------------------------------------------
  assign sel_coef  = lane_coef[rd_lvl];
  assign sel_flags = lane_flags[rd_lvl];
  assign sel_avail = lane_avail[rd_lvl];

  // back to level 0 after a coefficient flagged eol
  pcg_level_rotor rd_rotor_inst (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .step     (in_inc),
    .eol      (sel_flags[`PCG_FLAG_EOL]),
    .lvl      (rd_lvl),
    .lvl_mask (rd_mask)
  );

  // output register
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_avail <= 1'b0;
    end else begin
      out_avail <= sel_avail;
    end
  end

  always_ff @(posedge clk) begin
    out_data  <= sel_coef;
    out_flags <= sel_flags;
  end

endmodule

`default_nettype wire

// File: verification/pcg_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcg_params.svh"

module pcg_pipe_tb
  import pcg_pkg::*;
();

  localparam int RST_CYC  = 8;
  localparam int ROUNDS   = 20;
  localparam int PER_LVL  = `PCG_DEPTH * `PCG_R;
  localparam int WDOG_CYC = RST_CYC + ROUNDS * (`PCG_LVL_NB * `PCG_DEPTH * (`PCG_R + 2) + 20);

  logic   clk;
  logic   s_rst_n;
  word_t  in_data;
  flags_t in_flags;
  logic   in_avail;
  logic   in_inc;
  coef_t  out_data;
  flags_t out_flags;
  logic   out_avail;

  int     err_cnt;
  int     chk_cnt;
  logic   chk_pend;

  // reference model with one coefficient list per level
  coef_t  mdl_coef  [`PCG_LVL_NB][PER_LVL];
  flags_t mdl_flags [`PCG_LVL_NB][PER_LVL];
  int     mdl_wr    [`PCG_LVL_NB];
  int     mdl_rd    [`PCG_LVL_NB];
  int     wr_lvl;
  int     rd_lvl;
  coef_t  exp_coef  [$];
  flags_t exp_flags [$];

  pcg_pipe_top pcg_pipe_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_err(input string msg);
    $display("ERR %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // level rotation, back to level 0 on eol
  function automatic int next_level(input int lvl, input logic eol);
    if (eol || lvl == `PCG_LVL_NB - 1) begin
      return 0;
    end
    return lvl + 1;
  endfunction

  // --------------------------------------------------
  // output checker, one cycle after each read
  // --------------------------------------------------
  always @(posedge clk) begin
    chk_pend <= in_inc;
  end

  always @(negedge clk) begin
    coef_t  exp_c;
    flags_t exp_f;
    if (chk_pend) begin
      exp_c = exp_coef.pop_front();
      exp_f = exp_flags.pop_front();
      chk_cnt++;
      if (out_avail !== 1'b1)
        report_err("out_avail low one cycle after a read");
      if (out_data !== exp_c)
        report_err($sformatf("out_data %h, expected %h", out_data, exp_c));
      if (out_flags !== exp_f)
        report_err($sformatf("out_flags %b, expected %b", out_flags, exp_f));
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    int          n_lvl;
    int          idx;
    int          nxt;
    logic        gap;
    word_t       w;
    flags_t      f;
    flags_t      cf;
    void'($urandom(32'hfee4));
    err_cnt  = 0;
    chk_cnt  = 0;
    wr_lvl   = 0;
    rd_lvl   = 0;
    s_rst_n  = 1'b0;
    in_data  = '0;
    in_flags = '0;
    in_avail = 1'b0;
    in_inc   = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    s_rst_n <= 1'b1;

    // nothing written yet
    repeat (4) begin
      @(negedge clk);
      if (out_avail !== 1'b0)
        report_err("out_avail high before any write");
    end

    for (int r = 0; r < ROUNDS; r++) begin
      n_lvl = 1 + int'($urandom % `PCG_LVL_NB);
      for (int l = 0; l < `PCG_LVL_NB; l++) begin
        mdl_wr[l] = 0;
        mdl_rd[l] = 0;
      end

      // write phase, levels in order and eol on the last one
      for (int k = 0; k < n_lvl * `PCG_DEPTH; k++) begin
        for (int i = 0; i < `PCG_R; i++) begin
          w[i*`PCG_OP_W +: `PCG_OP_W] = $urandom;
        end
        f = flags_t'($urandom);
        f[`PCG_FLAG_SOL] = (k % n_lvl == 0);
        f[`PCG_FLAG_EOL] = (k % n_lvl == n_lvl - 1);
        @(posedge clk);
        in_avail <= 1'b1;
        in_data  <= w;
        in_flags <= f;
        // sob only on coefficient 0, eob only on the last one
        for (int i = 0; i < `PCG_R; i++) begin
          cf = f;
          cf[`PCG_FLAG_SOB] = f[`PCG_FLAG_SOB] & (i == 0);
          cf[`PCG_FLAG_EOB] = f[`PCG_FLAG_EOB] & (i == `PCG_R - 1);
          mdl_coef[wr_lvl][mdl_wr[wr_lvl]]  = w[i*`PCG_OP_W +: `PCG_OP_W];
          mdl_flags[wr_lvl][mdl_wr[wr_lvl]] = cf;
          mdl_wr[wr_lvl]++;
        end
        wr_lvl = next_level(wr_lvl, f[`PCG_FLAG_EOL]);
        if (($urandom % 4) == 0) begin
          @(posedge clk);
          in_avail <= 1'b0;
        end
      end
      @(posedge clk);
      in_avail <= 1'b0;
      repeat (4) @(posedge clk);

      // read phase
      for (int k = 0; k < n_lvl * PER_LVL; k++) begin
        idx = mdl_rd[rd_lvl];
        @(posedge clk);
        in_inc <= 1'b1;
        exp_coef.push_back(mdl_coef[rd_lvl][idx]);
        exp_flags.push_back(mdl_flags[rd_lvl][idx]);
        mdl_rd[rd_lvl]++;
        nxt = next_level(rd_lvl, mdl_flags[rd_lvl][idx][`PCG_FLAG_EOL]);
        // a drained lane needs one cycle to reload before the same level is read
        gap = ((idx % `PCG_R) == `PCG_R - 1) && (nxt == rd_lvl);
        rd_lvl = nxt;
        if (gap || (($urandom % 4) == 0)) begin
          @(posedge clk);
          in_inc <= 1'b0;
        end
      end
      @(posedge clk);
      in_inc <= 1'b0;

      // round fully drained
      repeat (3) @(negedge clk);
      if (out_avail !== 1'b0)
        report_err("out_avail high after the round drained");
    end

    $display("errors: %0d  checks: %0d", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WDOG_CYC);
    $display("errors: %0d  checks: %0d", err_cnt, chk_cnt);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: pcg_pipe.f
+incdir+include
hw/pcg_pkg.sv
hw/pcg_level_rotor.sv
hw/pcg_acc_sreg.sv
hw/pcg_dist_sreg.sv
hw/pcg_pipe_top.sv
verification/pcg_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module pcg_pipe_tb -Mdir obj_dir -f pcg_pipe.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/Vpcg_pipe_tb)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1
